// ==== hdl/xt_chipset_pkg.sv ====
/*
 * XT chipset shared definitions
 * Bus widths, bus owner and command encodings, I/O port map
 */
`default_nettype none

package xt_chipset_pkg;

    parameter int ADDR_WIDTH    = 20;
    parameter int DATA_WIDTH    = 8;
    parameter int IO_ADDR_WIDTH = 10;

    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_CPU,
        OWNER_DMA
    } bus_owner_t;

    typedef enum logic [2:0] {
        CMD_IDLE,
        CMD_MEM_READ,
        CMD_MEM_WRITE,
        CMD_IO_READ,
        CMD_IO_WRITE
    } bus_cmd_t;

    // Only the low IO_ADDR_WIDTH bits are decoded, as on the XT
    parameter logic [IO_ADDR_WIDTH-1:0] TIMER_DIVISOR_PORT = 10'h041;
    parameter logic [IO_ADDR_WIDTH-1:0] REFRESH_COUNT_PORT = 10'h080;

    parameter logic [DATA_WIDTH-1:0] DEFAULT_DIVISOR = 8'd18;

endpackage

`default_nettype wire

// ==== hdl/interval_timer.sv ====
/*
 * Interval timer
 * Reloadable down counter, output toggles on every reload
 */
`timescale 1ns/1ps
`default_nettype none

module interval_timer (
    input  wire logic                                   clock,
    input  wire logic                                   reset,
    input  wire logic [xt_chipset_pkg::DATA_WIDTH-1:0]  divisor,
    output logic                                        timer_out
);

    logic [xt_chipset_pkg::DATA_WIDTH-1:0] count;

    // New divisor only takes effect at the next reload
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            count     <= xt_chipset_pkg::DEFAULT_DIVISOR;
            timer_out <= 1'b0;
        end else if (count == '0) begin
            count     <= divisor;
            timer_out <= ~timer_out;
        end else begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/io_registers.sv ====
/*
 * I/O register block
 * Timer divisor at port 0x041, refresh count at port 0x080
 */
`timescale 1ns/1ps
`default_nettype none

module io_registers (
    input  wire logic                                   clock,
    input  wire logic                                   reset,
    input  wire xt_chipset_pkg::bus_cmd_t               bus_cmd,
    input  wire logic [xt_chipset_pkg::ADDR_WIDTH-1:0]  bus_address,
    input  wire logic [xt_chipset_pkg::DATA_WIDTH-1:0]  bus_wdata,
    input  wire logic                                   refresh_done,
    output logic [xt_chipset_pkg::DATA_WIDTH-1:0]       io_rdata,
    output logic [xt_chipset_pkg::DATA_WIDTH-1:0]       divisor
);

    logic [xt_chipset_pkg::IO_ADDR_WIDTH-1:0]   io_port;
    logic [7:0]                                 refresh_count;

    assign io_port = bus_address[xt_chipset_pkg::IO_ADDR_WIDTH-1:0];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            divisor       <= xt_chipset_pkg::DEFAULT_DIVISOR;
            refresh_count <= '0;
        end else begin
            if (bus_cmd == xt_chipset_pkg::CMD_IO_WRITE &&
                io_port == xt_chipset_pkg::TIMER_DIVISOR_PORT)
                divisor <= bus_wdata;
            // Wraps at 256
            if (refresh_done)
                refresh_count <= refresh_count + 1'b1;
        end
    end

    always_comb begin
        io_rdata = '1;
        if (bus_cmd == xt_chipset_pkg::CMD_IO_READ) begin
            case (io_port)
                xt_chipset_pkg::TIMER_DIVISOR_PORT: io_rdata = divisor;
                xt_chipset_pkg::REFRESH_COUNT_PORT: io_rdata = refresh_count;
                default:                            io_rdata = '1;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ram_block.sv ====
/*
 * On-chip RAM
 * Synchronous byte memory at the bottom of the address space
 */
`timescale 1ns/1ps
`default_nettype none

module ram_block #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  wire logic                                   clock,
    input  wire xt_chipset_pkg::bus_cmd_t               bus_cmd,
    input  wire logic [xt_chipset_pkg::ADDR_WIDTH-1:0]  bus_address,
    input  wire logic [xt_chipset_pkg::DATA_WIDTH-1:0]  bus_wdata,
    output logic [xt_chipset_pkg::DATA_WIDTH-1:0]       ram_rdata
);

    logic [xt_chipset_pkg::DATA_WIDTH-1:0] mem [2**RAM_ADDR_WIDTH];
    logic                                  in_range;
    logic [RAM_ADDR_WIDTH-1:0]             index;

    assign in_range = (bus_address[xt_chipset_pkg::ADDR_WIDTH-1:RAM_ADDR_WIDTH] == '0);
    assign index    = bus_address[RAM_ADDR_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (bus_cmd == xt_chipset_pkg::CMD_MEM_WRITE && in_range)
            mem[index] <= bus_wdata;
        // Undecoded addresses float high
        if (bus_cmd == xt_chipset_pkg::CMD_MEM_READ)
            ram_rdata <= in_range ? mem[index] : '1;
    end

endmodule

`default_nettype wire

// ==== hdl/bus_arbiter.sv ====
/*
 * System bus arbiter
 * Grants the bus to CPU or refresh DMA and drives the granted master onto it
 */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire logic                                   clock,
    input  wire logic                                   reset,
    input  wire logic                                   cpu_bus_req,
    input  wire xt_chipset_pkg::bus_cmd_t               cpu_bus_cmd,
    input  wire logic [xt_chipset_pkg::ADDR_WIDTH-1:0]  cpu_bus_address,
    input  wire logic [xt_chipset_pkg::DATA_WIDTH-1:0]  cpu_bus_wdata,
    input  wire logic                                   dma_bus_req,
    input  wire xt_chipset_pkg::bus_cmd_t               dma_bus_cmd,
    input  wire logic [xt_chipset_pkg::ADDR_WIDTH-1:0]  dma_bus_address,
    input  wire logic                                   cpu_lock,
    output xt_chipset_pkg::bus_owner_t                  grant,
    output xt_chipset_pkg::bus_cmd_t                    bus_cmd,
    output logic [xt_chipset_pkg::ADDR_WIDTH-1:0]       bus_address,
    output logic [xt_chipset_pkg::DATA_WIDTH-1:0]       bus_wdata
);

    // Owner changes always pass through OWNER_NONE for one cycle
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            grant <= xt_chipset_pkg::OWNER_NONE;
        end else begin
            case (grant)
                xt_chipset_pkg::OWNER_NONE: begin
                    // Refresh wins a tie unless the CPU holds the bus locked
                    if (dma_bus_req && !cpu_lock)
                        grant <= xt_chipset_pkg::OWNER_DMA;
                    else if (cpu_bus_req)
                        grant <= xt_chipset_pkg::OWNER_CPU;
                end
                xt_chipset_pkg::OWNER_CPU: begin
                    if (!cpu_bus_req)
                        grant <= xt_chipset_pkg::OWNER_NONE;
                end
                xt_chipset_pkg::OWNER_DMA: begin
                    if (!dma_bus_req)
                        grant <= xt_chipset_pkg::OWNER_NONE;
                end
                default: grant <= xt_chipset_pkg::OWNER_NONE;
            endcase
        end
    end

    always_comb begin
        bus_cmd     = xt_chipset_pkg::CMD_IDLE;
        bus_address = '0;
        bus_wdata   = '0;
        if (grant == xt_chipset_pkg::OWNER_CPU && cpu_bus_req) begin
            bus_cmd     = cpu_bus_cmd;
            bus_address = cpu_bus_address;
            bus_wdata   = cpu_bus_wdata;
        end else if (grant == xt_chipset_pkg::OWNER_DMA && dma_bus_req) begin
            bus_cmd     = dma_bus_cmd;
            bus_address = dma_bus_address;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_bus_interface.sv ====
/*
 * CPU bus interface
 * Runs memory and I/O cycles on the system bus, inserts memory wait states
 * and returns read data with a one-cycle ready pulse
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_interface #(
    parameter int MEM_WAIT_STATES = 1
) (
    input  wire logic                                   clock,
    input  wire logic                                   reset,
    input  wire logic                                   cpu_req,
    input  wire xt_chipset_pkg::bus_cmd_t               cpu_cmd,
    input  wire logic [xt_chipset_pkg::ADDR_WIDTH-1:0]  cpu_address,
    input  wire logic [xt_chipset_pkg::DATA_WIDTH-1:0]  cpu_wdata,
    input  wire xt_chipset_pkg::bus_owner_t             grant,
    input  wire logic [xt_chipset_pkg::DATA_WIDTH-1:0]  ram_rdata,
    input  wire logic [xt_chipset_pkg::DATA_WIDTH-1:0]  io_rdata,
    output logic                                        cpu_ready,
    output logic [xt_chipset_pkg::DATA_WIDTH-1:0]       cpu_rdata,
    output logic                                        cpu_bus_req,
    output xt_chipset_pkg::bus_cmd_t                    cpu_bus_cmd,
    output logic [xt_chipset_pkg::ADDR_WIDTH-1:0]       cpu_bus_address,
    output logic [xt_chipset_pkg::DATA_WIDTH-1:0]       cpu_bus_wdata
);

    localparam int WAIT_WIDTH = $clog2(MEM_WAIT_STATES + 2);
    localparam logic [WAIT_WIDTH-1:0] WAIT_LAST = WAIT_WIDTH'(MEM_WAIT_STATES - 1);

    typedef enum logic [1:0] {
        ST_REQUEST,
        ST_TRANSFER,
        ST_WAIT,
        ST_DONE
    } state_t;

    state_t                 state;
    logic [WAIT_WIDTH-1:0]  wait_count;
    logic                   is_io;
    logic                   granted;

    assign is_io = (cpu_cmd == xt_chipset_pkg::CMD_IO_READ) ||
                   (cpu_cmd == xt_chipset_pkg::CMD_IO_WRITE);
    assign granted = cpu_req && (grant == xt_chipset_pkg::OWNER_CPU);

    // Request is released in the ready cycle so the arbiter can let go
    assign cpu_bus_req     = cpu_req && (state != ST_DONE);
    assign cpu_bus_cmd     = cpu_cmd;
    assign cpu_bus_address = cpu_address;
    assign cpu_bus_wdata   = cpu_wdata;
    assign cpu_ready       = (state == ST_DONE);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state      <= ST_REQUEST;
            wait_count <= '0;
        end else begin
            case (state)
                ST_REQUEST: begin
                    if (granted) begin
                        if (is_io) begin
                            state <= ST_DONE;
                        end else if (MEM_WAIT_STATES == 0) begin
                            state <= ST_TRANSFER;
                        end else begin
                            state      <= ST_WAIT;
                            wait_count <= '0;
                        end
                    end
                end
                ST_WAIT: begin
                    if (wait_count == WAIT_LAST)
                        state <= ST_TRANSFER;
                    else
                        wait_count <= wait_count + 1'b1;
                end
                ST_TRANSFER: state <= ST_DONE;
                ST_DONE:     state <= ST_REQUEST;
                default:     state <= ST_REQUEST;
            endcase
        end
    end

    // I/O data is combinational in the grant cycle, RAM data lags by one
    always_ff @(posedge clock) begin
        if (state == ST_REQUEST && granted && is_io)
            cpu_rdata <= io_rdata;
        else if (state == ST_TRANSFER)
            cpu_rdata <= ram_rdata;
    end

endmodule

`default_nettype wire

// ==== hdl/refresh_dma.sv ====
/*
 * Refresh DMA channel 0
 * Raises DRQ0 on each timer rising edge and runs refresh reads once granted
 */
`timescale 1ns/1ps
`default_nettype none

module refresh_dma #(
    parameter int REFRESH_CYCLES = 2
) (
    input  wire logic                               clock,
    input  wire logic                               reset,
    input  wire logic                               timer_out,
    input  wire xt_chipset_pkg::bus_owner_t         grant,
    output logic                                    dma_bus_req,
    output xt_chipset_pkg::bus_cmd_t                dma_bus_cmd,
    output logic [xt_chipset_pkg::ADDR_WIDTH-1:0]   dma_bus_address,
    output logic                                    refresh_done
);

    localparam int COUNT_WIDTH = $clog2(REFRESH_CYCLES + 1);

    logic                   timer_prev;
    logic                   drq0;
    logic [COUNT_WIDTH-1:0] cycles_left;
    logic [7:0]             refresh_row;
    logic                   owned;
    logic                   start;
    logic                   last;

    assign owned = (grant == xt_chipset_pkg::OWNER_DMA) && dma_bus_req;
    assign start = owned && drq0 && (cycles_left == '0);
    assign last  = owned && (start ? (REFRESH_CYCLES == 1) : (cycles_left == 1));

    assign dma_bus_req     = drq0 || (cycles_left != '0);
    assign dma_bus_cmd     = dma_bus_req ? xt_chipset_pkg::CMD_MEM_READ
                                         : xt_chipset_pkg::CMD_IDLE;
    assign dma_bus_address = xt_chipset_pkg::ADDR_WIDTH'(refresh_row);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            timer_prev   <= 1'b0;
            drq0         <= 1'b0;
            cycles_left  <= '0;
            refresh_row  <= '0;
            refresh_done <= 1'b0;
        end else begin
            timer_prev   <= timer_out;
            refresh_done <= last;

            // Acknowledge clears DRQ0 and absorbs any edge in the same cycle
            if (grant == xt_chipset_pkg::OWNER_DMA)
                drq0 <= 1'b0;
            else if (timer_out && !timer_prev)
                drq0 <= 1'b1;

            if (start)
                cycles_left <= COUNT_WIDTH'(REFRESH_CYCLES - 1);
            else if (owned)
                cycles_left <= cycles_left - 1'b1;

            // One row per bus cycle
            if (owned)
                refresh_row <= refresh_row + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/xt_chipset.sv ====
/*
 * Cut-down XT system chipset
 * CPU bus interface and refresh DMA share one arbitrated system bus
 */
`timescale 1ns/1ps
`default_nettype none

module xt_chipset #(
    parameter int RAM_ADDR_WIDTH  = 10,
    parameter int MEM_WAIT_STATES = 1,
    parameter int REFRESH_CYCLES  = 2
) (
    input  wire logic                                   clock,
    input  wire logic                                   reset,
    input  wire logic                                   cpu_req,
    input  wire xt_chipset_pkg::bus_cmd_t               cpu_cmd,
    input  wire logic [xt_chipset_pkg::ADDR_WIDTH-1:0]  cpu_address,
    input  wire logic [xt_chipset_pkg::DATA_WIDTH-1:0]  cpu_wdata,
    input  wire logic                                   cpu_lock,
    output logic                                        cpu_ready,
    output logic [xt_chipset_pkg::DATA_WIDTH-1:0]       cpu_rdata
);

    xt_chipset_pkg::bus_owner_t                 grant;
    xt_chipset_pkg::bus_cmd_t                   bus_cmd;
    logic [xt_chipset_pkg::ADDR_WIDTH-1:0]      bus_address;
    logic [xt_chipset_pkg::DATA_WIDTH-1:0]      bus_wdata;

    logic                                       cpu_bus_req;
    xt_chipset_pkg::bus_cmd_t                   cpu_bus_cmd;
    logic [xt_chipset_pkg::ADDR_WIDTH-1:0]      cpu_bus_address;
    logic [xt_chipset_pkg::DATA_WIDTH-1:0]      cpu_bus_wdata;

    logic                                       dma_bus_req;
    xt_chipset_pkg::bus_cmd_t                   dma_bus_cmd;
    logic [xt_chipset_pkg::ADDR_WIDTH-1:0]      dma_bus_address;

    logic [xt_chipset_pkg::DATA_WIDTH-1:0]      ram_rdata;
    logic [xt_chipset_pkg::DATA_WIDTH-1:0]      io_rdata;
    logic [xt_chipset_pkg::DATA_WIDTH-1:0]      divisor;
    logic                                       timer_out;
    logic                                       refresh_done;

    cpu_bus_interface #(
        .MEM_WAIT_STATES    (MEM_WAIT_STATES)
    ) u_cpu_bus_interface (
        .clock              (clock),
        .reset              (reset),
        .cpu_req            (cpu_req),
        .cpu_cmd            (cpu_cmd),
        .cpu_address        (cpu_address),
        .cpu_wdata          (cpu_wdata),
        .grant              (grant),
        .ram_rdata          (ram_rdata),
        .io_rdata           (io_rdata),
        .cpu_ready          (cpu_ready),
        .cpu_rdata          (cpu_rdata),
        .cpu_bus_req        (cpu_bus_req),
        .cpu_bus_cmd        (cpu_bus_cmd),
        .cpu_bus_address    (cpu_bus_address),
        .cpu_bus_wdata      (cpu_bus_wdata)
    );

    refresh_dma #(
        .REFRESH_CYCLES     (REFRESH_CYCLES)
    ) u_refresh_dma (
        .clock              (clock),
        .reset              (reset),
        .timer_out          (timer_out),
        .grant              (grant),
        .dma_bus_req        (dma_bus_req),
        .dma_bus_cmd        (dma_bus_cmd),
        .dma_bus_address    (dma_bus_address),
        .refresh_done       (refresh_done)
    );

    bus_arbiter u_bus_arbiter (
        .clock              (clock),
        .reset              (reset),
        .cpu_bus_req        (cpu_bus_req),
        .cpu_bus_cmd        (cpu_bus_cmd),
        .cpu_bus_address    (cpu_bus_address),
        .cpu_bus_wdata      (cpu_bus_wdata),
        .dma_bus_req        (dma_bus_req),
        .dma_bus_cmd        (dma_bus_cmd),
        .dma_bus_address    (dma_bus_address),
        .cpu_lock           (cpu_lock),
        .grant              (grant),
        .bus_cmd            (bus_cmd),
        .bus_address        (bus_address),
        .bus_wdata          (bus_wdata)
    );

    interval_timer u_interval_timer (
        .clock              (clock),
        .reset              (reset),
        .divisor            (divisor),
        .timer_out          (timer_out)
    );

    io_registers u_io_registers (
        .clock              (clock),
        .reset              (reset),
        .bus_cmd            (bus_cmd),
        .bus_address        (bus_address),
        .bus_wdata          (bus_wdata),
        .refresh_done       (refresh_done),
        .io_rdata           (io_rdata),
        .divisor            (divisor)
    );

    ram_block #(
        .RAM_ADDR_WIDTH     (RAM_ADDR_WIDTH)
    ) u_ram_block (
        .clock              (clock),
        .bus_cmd            (bus_cmd),
        .bus_address        (bus_address),
        .bus_wdata          (bus_wdata),
        .ram_rdata          (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== verif/xt_chipset_sva.sv ====
/*
 * XT chipset bus assertions
 * Ready handshake, owner changes through idle, and the CPU lock rule
 */
`timescale 1ns/1ps
`default_nettype none

module xt_chipset_sva (
    input wire logic                        clock,
    input wire logic                        reset,
    input wire logic                        cpu_req,
    input wire logic                        cpu_ready,
    input wire xt_chipset_pkg::bus_owner_t  grant,
    input wire logic                        cpu_lock
);

    ready_pulse: assert property (@(posedge clock) disable iff (reset)
        cpu_ready |=> !cpu_ready)
        else $error("cpu_ready stayed high for more than one cycle");

    ready_with_req: assert property (@(posedge clock) disable iff (reset)
        cpu_ready |-> cpu_req)
        else $error("cpu_ready without a pending cpu_req");

    cpu_to_dma: assert property (@(posedge clock) disable iff (reset)
        grant == xt_chipset_pkg::OWNER_CPU |=> grant != xt_chipset_pkg::OWNER_DMA)
        else $error("grant moved from CPU to DMA without an idle cycle");

    dma_to_cpu: assert property (@(posedge clock) disable iff (reset)
        grant == xt_chipset_pkg::OWNER_DMA |=> grant != xt_chipset_pkg::OWNER_CPU)
        else $error("grant moved from DMA to CPU without an idle cycle");

    lock_holds_dma: assert property (@(posedge clock) disable iff (reset)
        (grant != xt_chipset_pkg::OWNER_DMA && cpu_lock) |=> grant != xt_chipset_pkg::OWNER_DMA)
        else $error("DMA grant started while cpu_lock was high");

endmodule

// Handshake side sees no lock, arbiter side sees no ready
bind cpu_bus_interface xt_chipset_sva handshake_sva_i (
    .clock      (clock),
    .reset      (reset),
    .cpu_req    (cpu_req),
    .cpu_ready  (cpu_ready),
    .grant      (grant),
    .cpu_lock   (1'b0)
);

bind bus_arbiter xt_chipset_sva arbiter_sva_i (
    .clock      (clock),
    .reset      (reset),
    .cpu_req    (1'b0),
    .cpu_ready  (1'b0),
    .grant      (grant),
    .cpu_lock   (cpu_lock)
);

`default_nettype wire

// ==== verif/xt_chipset_tb.sv ====
/*
 * XT chipset testbench
 * Runs a table of CPU bus cycles and checks read data, refresh rate and lock
 */
`timescale 1ns/1ps
`default_nettype none

module xt_chipset_tb;

    localparam int RAM_ADDR_WIDTH  = 10;
    localparam int MEM_WAIT_STATES = 1;
    localparam int REFRESH_CYCLES  = 2;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_STEPS       = 18;

    localparam logic [19:0] DIVISOR_ADDR = 20'(xt_chipset_pkg::TIMER_DIVISOR_PORT);
    localparam logic [19:0] COUNT_ADDR   = 20'(xt_chipset_pkg::REFRESH_COUNT_PORT);

    typedef enum logic [1:0] {
        CHECK_NONE,
        CHECK_EXACT,
        CHECK_RATE,
        CHECK_LOCK
    } check_t;

    typedef struct packed {
        logic [8*10-1:0]            name;
        xt_chipset_pkg::bus_cmd_t   cmd;
        logic [19:0]                address;
        logic [7:0]                 wdata;
        logic [7:0]                 expected;
        logic [15:0]                idle;
        logic                       lock;
        check_t                     check;
    } step_t;

    logic                       clock;
    logic                       reset;
    logic                       cpu_req;
    xt_chipset_pkg::bus_cmd_t   cpu_cmd;
    logic [19:0]                cpu_address;
    logic [7:0]                 cpu_wdata;
    logic                       cpu_lock;
    logic                       cpu_ready;
    logic [7:0]                 cpu_rdata;

    step_t      table_steps [NUM_STEPS];
    integer     seed;
    int         cycle_count = 0;
    int         cycle_limit;
    int         prev_idle;
    logic [7:0] last_count;
    logic [7:0] model_divisor;

    xt_chipset #(
        .RAM_ADDR_WIDTH     (RAM_ADDR_WIDTH),
        .MEM_WAIT_STATES    (MEM_WAIT_STATES),
        .REFRESH_CYCLES     (REFRESH_CYCLES)
    ) dut_i (
        .clock              (clock),
        .reset              (reset),
        .cpu_req            (cpu_req),
        .cpu_cmd            (cpu_cmd),
        .cpu_address        (cpu_address),
        .cpu_wdata          (cpu_wdata),
        .cpu_lock           (cpu_lock),
        .cpu_ready          (cpu_ready),
        .cpu_rdata          (cpu_rdata)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    function automatic step_t make_step(
        input logic [8*10-1:0]          name,
        input xt_chipset_pkg::bus_cmd_t cmd,
        input logic [19:0]              address,
        input logic [7:0]               wdata,
        input logic [7:0]               expected,
        input int                       idle,
        input logic                     lock,
        input check_t                   check
    );
        step_t s;
        s.name     = name;
        s.cmd      = cmd;
        s.address  = address;
        s.wdata    = wdata;
        s.expected = expected;
        s.idle     = 16'(idle);
        s.lock     = lock;
        s.check    = check;
        return s;
    endfunction

    function automatic string mismatch_line(input logic [8*10-1:0] name, input int expected,
                                            input int actual);
        return $sformatf("FAILED %0s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    endfunction

    task automatic stop_on_error(input string line);
        $display("%0s", line);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic build_table();
        logic [7:0] rnd [4];
        for (int i = 0; i < 4; i++)
            rnd[i] = 8'($random(seed));
        table_steps[0]  = make_step("div_reset", xt_chipset_pkg::CMD_IO_READ, DIVISOR_ADDR, 8'h00,
                                    xt_chipset_pkg::DEFAULT_DIVISOR, 0, 1'b0, CHECK_EXACT);
        table_steps[1]  = make_step("io_undec", xt_chipset_pkg::CMD_IO_READ, 20'h00060, 8'h00,
                                    8'hff, 0, 1'b0, CHECK_EXACT);
        table_steps[2]  = make_step("mem_wr0", xt_chipset_pkg::CMD_MEM_WRITE, 20'h00000, rnd[0],
                                    8'h00, 0, 1'b0, CHECK_NONE);
        table_steps[3]  = make_step("mem_wr1", xt_chipset_pkg::CMD_MEM_WRITE, 20'h00155, rnd[1],
                                    8'h00, 0, 1'b0, CHECK_NONE);
        table_steps[4]  = make_step("mem_wr2", xt_chipset_pkg::CMD_MEM_WRITE, 20'h002aa, rnd[2],
                                    8'h00, 0, 1'b0, CHECK_NONE);
        table_steps[5]  = make_step("mem_wr3", xt_chipset_pkg::CMD_MEM_WRITE, 20'h003ff, rnd[3],
                                    8'h00, 0, 1'b0, CHECK_NONE);
        table_steps[6]  = make_step("mem_rd0", xt_chipset_pkg::CMD_MEM_READ, 20'h00000, 8'h00,
                                    rnd[0], 0, 1'b0, CHECK_EXACT);
        table_steps[7]  = make_step("mem_rd3", xt_chipset_pkg::CMD_MEM_READ, 20'h003ff, 8'h00,
                                    rnd[3], 0, 1'b0, CHECK_EXACT);
        table_steps[8]  = make_step("mem_oor", xt_chipset_pkg::CMD_MEM_READ, 20'h00400, 8'h00,
                                    8'hff, 0, 1'b0, CHECK_EXACT);
        table_steps[9]  = make_step("mem_high", xt_chipset_pkg::CMD_MEM_READ, 20'hf0155, 8'h00,
                                    8'hff, 0, 1'b0, CHECK_EXACT);
        // Idle time lets the timer reload with the new divisor
        table_steps[10] = make_step("div_wr", xt_chipset_pkg::CMD_IO_WRITE, DIVISOR_ADDR, 8'd9,
                                    8'h00, 60, 1'b0, CHECK_NONE);
        table_steps[11] = make_step("div_rd", xt_chipset_pkg::CMD_IO_READ, DIVISOR_ADDR, 8'h00,
                                    8'd9, 0, 1'b0, CHECK_EXACT);
        table_steps[12] = make_step("cnt_base", xt_chipset_pkg::CMD_IO_READ, COUNT_ADDR, 8'h00,
                                    8'h00, 400, 1'b0, CHECK_NONE);
        table_steps[13] = make_step("cnt_rate", xt_chipset_pkg::CMD_IO_READ, COUNT_ADDR, 8'h00,
                                    8'h00, 200, 1'b1, CHECK_RATE);
        table_steps[14] = make_step("cnt_lock", xt_chipset_pkg::CMD_IO_READ, COUNT_ADDR, 8'h00,
                                    8'h00, 0, 1'b0, CHECK_LOCK);
        table_steps[15] = make_step("keep_rd1", xt_chipset_pkg::CMD_MEM_READ, 20'h00155, 8'h00,
                                    rnd[1], 0, 1'b0, CHECK_EXACT);
        table_steps[16] = make_step("keep_rd2", xt_chipset_pkg::CMD_MEM_READ, 20'h002aa, 8'h00,
                                    rnd[2], 0, 1'b0, CHECK_EXACT);
        table_steps[17] = make_step("keep_rd0", xt_chipset_pkg::CMD_MEM_READ, 20'h00000, 8'h00,
                                    rnd[0], 0, 1'b0, CHECK_EXACT);
    endtask

    task automatic run_step(input step_t s);
        int         latency;
        int         min_latency;
        int         expected_delta;
        logic [7:0] delta;
        logic       is_io;
        is_io = (s.cmd == xt_chipset_pkg::CMD_IO_READ) || (s.cmd == xt_chipset_pkg::CMD_IO_WRITE);
        min_latency = is_io ? 2 : MEM_WAIT_STATES + 2;
        cpu_req     = 1'b1;
        cpu_cmd     = s.cmd;
        cpu_address = s.address;
        cpu_wdata   = s.wdata;

        latency = 0;
        @(negedge clock);
        while (!cpu_ready) begin
            @(negedge clock);
            latency++;
        end
        assert (latency >= min_latency) else
            stop_on_error($sformatf("%0s finished after %0d cycles, below the minimum of %0d",
                                    s.name, latency, min_latency));

        delta = cpu_rdata - last_count;
        expected_delta = prev_idle / (2 * (int'(model_divisor) + 1));
        case (s.check)
            CHECK_EXACT: assert (cpu_rdata == s.expected) else
                stop_on_error(mismatch_line(s.name, s.expected, cpu_rdata));
            CHECK_RATE: assert (int'(delta) + 1 >= expected_delta &&
                                int'(delta) <= expected_delta + 1) else
                stop_on_error(mismatch_line(s.name, expected_delta, delta));
            CHECK_LOCK: assert (delta <= 8'd1) else
                stop_on_error(mismatch_line(s.name, 1, delta));
            default: ;
        endcase

        if (s.cmd == xt_chipset_pkg::CMD_IO_READ && s.address == COUNT_ADDR)
            last_count = cpu_rdata;
        if (s.cmd == xt_chipset_pkg::CMD_IO_WRITE && s.address == DIVISOR_ADDR)
            model_divisor = s.wdata;
        prev_idle = s.idle;

        @(posedge clock);
        #2;
        cpu_req  = 1'b0;
        cpu_cmd  = xt_chipset_pkg::CMD_IDLE;
        cpu_lock = s.lock;
        repeat (s.idle) begin
            @(posedge clock);
            #2;
        end
        cpu_lock = 1'b0;
    endtask

    initial begin
        seed          = 32'h5183_ef23;
        clock         = 1'b0;
        reset         = 1'b1;
        cpu_req       = 1'b0;
        cpu_cmd       = xt_chipset_pkg::CMD_IDLE;
        cpu_address   = '0;
        cpu_wdata     = '0;
        cpu_lock      = 1'b0;
        prev_idle     = 0;
        last_count    = '0;
        model_divisor = xt_chipset_pkg::DEFAULT_DIVISOR;

        build_table();
        cycle_limit = RESET_CYCLES + 64 * NUM_STEPS;
        for (int i = 0; i < NUM_STEPS; i++)
            cycle_limit += int'(table_steps[i].idle);

        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;

        for (int i = 0; i < NUM_STEPS; i++)
            run_step(table_steps[i]);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== xt_chipset.f ====
hdl/xt_chipset_pkg.sv
hdl/interval_timer.sv
hdl/io_registers.sv
hdl/ram_block.sv
hdl/bus_arbiter.sv
hdl/cpu_bus_interface.sv
hdl/refresh_dma.sv
hdl/xt_chipset.sv
verif/xt_chipset_sva.sv
verif/xt_chipset_tb.sv

// ==== Makefile ====
# Verilator build and run for the XT chipset testbench

TOP = xt_chipset_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f xt_chipset.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Test failures found" >> sim.log
	@cat sim.log
	@if grep -q "Test failures found" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing -f xt_chipset.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
